// ==== flist.f ====
+incdir+verilog
verilog/lc_fuse_pkg.sv
verilog/lc_cmd_decode.sv
verilog/lc_state_transition.sv
verilog/fuse_write_filter.sv
verilog/fuse_result.sv
verilog/lc_fuse_top.sv
bench/lc_fuse_chk.sv
bench/lc_fuse_tb.sv

// ==== bench/lc_fuse_tb.sv ====
`include "lc_fuse_params.svh"

module lc_fuse_tb;

  localparam int TIMEOUT  = 20;
  localparam int NUM_RAND = 50;

  logic                         clk_i;
  logic                         rst_i;
  logic                         cmd_valid_i;
  logic [`LC_FUSE_CMD_W-1:0]    cmd_i;
  logic                         ppd_i;
  logic                         escalate_i;
  logic                         zeroize_i;
  logic                         rsp_valid_o;
  lc_fuse_pkg::lc_err_e         rsp_err_o;
  lc_fuse_pkg::lc_state_e       lc_state_o;
  logic                         escalated_o;
  logic [`LC_FUSE_BCAST_W-1:0]  broadcast_o;

  // Reference model state
  lc_fuse_pkg::lc_state_e       model_state;
  logic                         model_esc;
  logic [`LC_FUSE_WORD_W-1:0]   model_fuse [`LC_FUSE_NUM_PART];
  logic [31:0]                  lcg_state;

  lc_fuse_top u_lc_fuse_top (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .ppd_i       (ppd_i),
    .escalate_i  (escalate_i),
    .zeroize_i   (zeroize_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o),
    .lc_state_o  (lc_state_o),
    .escalated_o (escalated_o),
    .broadcast_o (broadcast_o)
  );

  always #50 clk_i = ~clk_i;

  // Overall limit on simulated time
  initial begin
    #1000000;
    $display("Timeout: simulation ran past its time limit");
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  // Any failed assertion in the bound checker ends the run
  always @(u_lc_fuse_top.u_lc_fuse_chk.fail_cnt) begin
    if (u_lc_fuse_top.u_lc_fuse_chk.fail_cnt != 0) begin
      $display("A bound assertion failed at time %0t", $time);
      $display("Checks failed");
      $fatal(1, "assertion failure");
    end
  end

  // Command words, opcode in the top two bits
  function automatic logic [31:0] wr_word(input logic [1:0] part, input logic [15:0] data);
    return {2'b01, part, 12'h000, data};
  endfunction

  function automatic logic [31:0] tr_word(input logic [3:0] target);
    return {2'b10, target, 26'h0};
  endfunction

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Last writable state per partition
  function automatic int phase_last(input logic [1:0] part);
    case (part)
      2'd0:    return 2;
      2'd1:    return 3;
      default: return 4;
    endcase
  endfunction

  function logic [63:0] model_bcast();
    if (model_state == lc_fuse_pkg::SCRAP) return 64'h0;
    return {model_fuse[3], model_fuse[2], model_fuse[1], model_fuse[0]};
  endfunction

  // Predicts one response and applies its effect
  task automatic model_cmd(input logic [31:0] word, input logic ppd,
                           output lc_fuse_pkg::lc_err_e err);
    logic [1:0] op;
    logic [1:0] part;
    logic [3:0] tgt;
    op   = word[31:30];
    part = word[29:28];
    tgt  = word[29:26];
    err  = lc_fuse_pkg::NoError;
    if (model_esc) begin
      err = lc_fuse_pkg::EscError;
    end else if (op == 2'd1) begin
      if ((part == 2'd3) || (model_state > phase_last(part))) err = lc_fuse_pkg::AccessError;
      else model_fuse[part] = model_fuse[part] | word[15:0];
    end else if ((op != 2'd2) || (tgt > 4'd7)) begin
      err = lc_fuse_pkg::OpcodeError;
    end else if ((tgt <= model_state) || ((model_state == lc_fuse_pkg::PROD_END) &&
                 (tgt == 4'd6)) || ((tgt >= 4'd6) && !ppd)) begin
      err = lc_fuse_pkg::TransError;
    end else begin
      model_state = lc_fuse_pkg::lc_state_e'(tgt[2:0]);
    end
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout at time %0t: no response arrived for %s", $time, what);
    $display("Checks failed");
    $fatal(1, "response timeout");
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i       <= 1'b1;
    cmd_valid_i <= 1'b0;
    cmd_i       <= '0;
    ppd_i       <= 1'b0;
    escalate_i  <= 1'b0;
    zeroize_i   <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i       <= 1'b0;
    model_state = lc_fuse_pkg::RAW;
    model_esc   = 1'b0;
    for (int i = 0; i < `LC_FUSE_NUM_PART; i++) model_fuse[i] = '0;
  endtask

  // One command, then response, state and broadcast against the model
  task automatic send_cmd(input logic [31:0] word, input lc_fuse_pkg::lc_err_e exp,
                          input string what);
    lc_fuse_pkg::lc_err_e model_err;
    int                   waited;
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_i       <= word;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    cmd_i       <= '0;
    // ppd level has settled by now
    model_cmd(word, ppd_i, model_err);
    waited = 0;
    while (rsp_valid_o !== 1'b1) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) fail_timeout(what);
    end
    // Model must agree with the hand-derived code before it is trusted
    check_value(model_err, exp, {what, ", model"});
    check_value(rsp_err_o, exp, what);
    check_value(lc_state_o, model_state, {what, ", state"});
    check_value(broadcast_o, model_bcast(), {what, ", broadcast"});
  endtask

  task automatic test_raw_writes();
    apply_reset();
    send_cmd(wr_word(2'd0, 16'h0011), lc_fuse_pkg::NoError, "RAW write p0");
    send_cmd(wr_word(2'd1, 16'h0300), lc_fuse_pkg::NoError, "RAW write p1");
    send_cmd(wr_word(2'd2, 16'h5000), lc_fuse_pkg::NoError, "RAW write p2");
    send_cmd(wr_word(2'd0, 16'h0100), lc_fuse_pkg::NoError, "RAW second write p0");
    send_cmd(wr_word(2'd3, 16'hffff), lc_fuse_pkg::AccessError, "RAW write p3");
    check_value(broadcast_o, 64'h0000_5000_0300_0111, "broadcast after RAW writes");
  endtask

  task automatic test_forward();
    apply_reset();
    send_cmd(wr_word(2'd0, 16'h000f), lc_fuse_pkg::NoError, "RAW write p0");
    send_cmd(tr_word(4'd2), lc_fuse_pkg::NoError, "RAW to TEST_LOCKED");
    check_value(lc_state_o, lc_fuse_pkg::TEST_LOCKED, "state after first transition");
    send_cmd(tr_word(4'd3), lc_fuse_pkg::NoError, "TEST_LOCKED to DEV");
    send_cmd(wr_word(2'd0, 16'h00f0), lc_fuse_pkg::AccessError, "DEV write p0");
    send_cmd(wr_word(2'd1, 16'h1234), lc_fuse_pkg::NoError, "DEV write p1");
    check_value(broadcast_o, 64'h0000_0000_1234_000f, "broadcast in DEV");
  endtask

  task automatic test_illegal();
    apply_reset();
    send_cmd(tr_word(4'd3), lc_fuse_pkg::NoError, "RAW to DEV");
    send_cmd(tr_word(4'd2), lc_fuse_pkg::TransError, "rollback");
    send_cmd(tr_word(4'd3), lc_fuse_pkg::TransError, "same-state request");
    send_cmd(tr_word(4'd6), lc_fuse_pkg::TransError, "RMA without ppd");
    send_cmd(tr_word(4'd5), lc_fuse_pkg::NoError, "DEV to PROD_END");
    @(posedge clk_i);
    ppd_i <= 1'b1;
    send_cmd(tr_word(4'd6), lc_fuse_pkg::TransError, "PROD_END to RMA");
    send_cmd(32'h0000_1234, lc_fuse_pkg::OpcodeError, "opcode 0");
    send_cmd(32'hc3ff_0000, lc_fuse_pkg::OpcodeError, "opcode 3");
    send_cmd(tr_word(4'd9), lc_fuse_pkg::OpcodeError, "target 9");
    check_value(lc_state_o, lc_fuse_pkg::PROD_END, "state after refused requests");
  endtask

  task automatic test_zeroize_scrap();
    apply_reset();
    send_cmd(wr_word(2'd0, 16'h00f0), lc_fuse_pkg::NoError, "write p0");
    send_cmd(wr_word(2'd2, 16'h0f00), lc_fuse_pkg::NoError, "write p2");
    // Broadcast reacts one cycle after the level is sampled
    @(posedge clk_i);
    zeroize_i <= 1'b1;
    repeat (2) @(negedge clk_i);
    check_value(broadcast_o, 64'h0, "broadcast under zeroize");
    repeat (3) @(negedge clk_i);
    check_value(broadcast_o, 64'h0, "broadcast still zero under zeroize");
    @(posedge clk_i);
    zeroize_i <= 1'b0;
    repeat (2) @(negedge clk_i);
    check_value(broadcast_o, 64'h0000_0f00_0000_00f0, "broadcast after zeroize release");
    @(posedge clk_i);
    ppd_i <= 1'b1;
    send_cmd(tr_word(4'd7), lc_fuse_pkg::NoError, "RAW to SCRAP");
    check_value(broadcast_o, 64'h0, "broadcast in SCRAP");
    send_cmd(wr_word(2'd1, 16'h0001), lc_fuse_pkg::AccessError, "SCRAP write p1");
    send_cmd(wr_word(2'd0, 16'h0001), lc_fuse_pkg::AccessError, "SCRAP write p0");
  endtask

  task automatic test_escalation();
    apply_reset();
    send_cmd(wr_word(2'd1, 16'h0042), lc_fuse_pkg::NoError, "write p1");
    send_cmd(tr_word(4'd1), lc_fuse_pkg::NoError, "RAW to TEST_UNLOCKED");
    @(posedge clk_i);
    escalate_i <= 1'b1;
    @(posedge clk_i);
    escalate_i <= 1'b0;
    @(negedge clk_i);
    check_value(escalated_o, 1'b1, "escalated after pulse");
    model_esc = 1'b1;
    send_cmd(wr_word(2'd0, 16'h0001), lc_fuse_pkg::EscError, "escalated write p0");
    send_cmd(tr_word(4'd3), lc_fuse_pkg::EscError, "escalated transition");
    send_cmd(32'h0000_0000, lc_fuse_pkg::EscError, "escalated opcode 0");
    send_cmd(wr_word(2'd3, 16'h0001), lc_fuse_pkg::EscError, "escalated write p3");
    check_value(lc_state_o, lc_fuse_pkg::TEST_UNLOCKED, "state under escalation");
    check_value(broadcast_o, 64'h0000_0000_0042_0000, "broadcast under escalation");
    check_value(escalated_o, 1'b1, "escalation stays set");
  endtask

  // Back-to-back commands, predicted in order
  task automatic test_random();
    logic [31:0]          words [$];
    lc_fuse_pkg::lc_err_e exps [$];
    logic [31:0]          hi;
    logic [31:0]          lo;
    lc_fuse_pkg::lc_err_e err;
    int                   got;
    int                   idle;
    apply_reset();
    for (int i = 0; i < NUM_RAND; i++) begin
      hi = lcg_next();
      lo = lcg_next();
      words.push_back({hi[31:16], lo[31:16]});
      // ppd stays low for the whole sequence
      model_cmd({hi[31:16], lo[31:16]}, 1'b0, err);
      exps.push_back(err);
    end
    fork
      begin
        foreach (words[i]) begin
          @(posedge clk_i);
          cmd_valid_i <= 1'b1;
          cmd_i       <= words[i];
        end
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
      end
      begin
        got  = 0;
        idle = 0;
        while (got < NUM_RAND) begin
          @(negedge clk_i);
          if (rsp_valid_o === 1'b1) begin
            check_value(rsp_err_o, exps[got], $sformatf("random command %0d", got));
            got++;
            idle = 0;
          end else begin
            idle++;
            if (idle > TIMEOUT) fail_timeout($sformatf("random command %0d", got));
          end
        end
      end
    join
    @(negedge clk_i);
    check_value(lc_state_o, model_state, "state after random sequence");
    check_value(broadcast_o, model_bcast(), "broadcast after random sequence");
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    ppd_i       = 1'b0;
    escalate_i  = 1'b0;
    zeroize_i   = 1'b0;
    lcg_state   = 32'd80526;
    test_raw_writes();
    test_forward();
    test_illegal();
    test_zeroize_scrap();
    test_escalation();
    test_random();
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== bench/lc_fuse_chk.sv ====
`include "lc_fuse_params.svh"

module lc_fuse_chk (
  input logic                         clk_i,
  input logic                         rst_i,
  input logic                         cmd_valid_i,
  input logic                         zeroize_i,
  input logic                         rsp_valid_i,
  input lc_fuse_pkg::lc_state_e       lc_state_i,
  input logic [`LC_FUSE_BCAST_W-1:0]  broadcast_i
);

  // Number of failed assertions so far
  int unsigned fail_cnt = 0;

  // Life cycle only moves forward between resets
  state_forward_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> (lc_state_i >= $past(lc_state_i)))
    else begin
      fail_cnt++;
      $error("life-cycle state moved backwards");
    end

  // Zeroize or SCRAP hides the fuse words one cycle later
  bcast_zero_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (zeroize_i || (lc_state_i == lc_fuse_pkg::SCRAP)) |=> (broadcast_i == '0))
    else begin
      fail_cnt++;
      $error("broadcast not cleared after zeroize or SCRAP");
    end

  // Fixed three-cycle latency, no back-pressure
  rsp_latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_valid_i |-> ##3 rsp_valid_i)
    else begin
      fail_cnt++;
      $error("no response three cycles after a command");
    end

endmodule

bind lc_fuse_top lc_fuse_chk u_lc_fuse_chk (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .cmd_valid_i (cmd_valid_i),
  .zeroize_i   (zeroize_i),
  .rsp_valid_i (rsp_valid_o),
  .lc_state_i  (lc_state_o),
  .broadcast_i (broadcast_o)
);

// ==== verilog/lc_fuse_top.sv ====
`include "lc_fuse_params.svh"

module lc_fuse_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         cmd_valid_i,
  input  logic [`LC_FUSE_CMD_W-1:0]    cmd_i,
  input  logic                         ppd_i,
  input  logic                         escalate_i,
  input  logic                         zeroize_i,
  output logic                         rsp_valid_o,
  output lc_fuse_pkg::lc_err_e         rsp_err_o,
  output lc_fuse_pkg::lc_state_e       lc_state_o,
  output logic                         escalated_o,
  output logic [`LC_FUSE_BCAST_W-1:0]  broadcast_o
);

  // Decode to execute
  logic                         dec_valid;
  lc_fuse_pkg::lc_op_e          dec_op;
  logic [`LC_FUSE_PART_W-1:0]   dec_part;
  logic [`LC_FUSE_WORD_W-1:0]   dec_data;
  lc_fuse_pkg::lc_state_e       dec_target;

  // Life-cycle block outputs
  lc_fuse_pkg::lc_state_e       lc_state;
  logic                         escalated;
  logic                         trans_valid;
  lc_fuse_pkg::lc_err_e         trans_err;

  // Fuse block outputs
  logic                         wr_valid;
  lc_fuse_pkg::lc_err_e         wr_err;
  logic [`LC_FUSE_BCAST_W-1:0]  fuse_words;

  // Raw word enters the decode stage as the union
  lc_cmd_decode u_lc_cmd_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (lc_fuse_pkg::lc_cmd_u'(cmd_i)),
    .dec_valid_o  (dec_valid),
    .dec_op_o     (dec_op),
    .dec_part_o   (dec_part),
    .dec_data_o   (dec_data),
    .dec_target_o (dec_target)
  );

  lc_state_transition u_lc_state_transition (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .dec_valid_i   (dec_valid),
    .dec_op_i      (dec_op),
    .dec_target_i  (dec_target),
    .ppd_i         (ppd_i),
    .escalate_i    (escalate_i),
    .lc_state_o    (lc_state),
    .escalated_o   (escalated),
    .trans_valid_o (trans_valid),
    .trans_err_o   (trans_err)
  );

  fuse_write_filter u_fuse_write_filter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .dec_valid_i  (dec_valid),
    .dec_op_i     (dec_op),
    .dec_part_i   (dec_part),
    .dec_data_i   (dec_data),
    .lc_state_i   (lc_state),
    .escalated_i  (escalated),
    .wr_valid_o   (wr_valid),
    .wr_err_o     (wr_err),
    .fuse_words_o (fuse_words)
  );

  fuse_result u_fuse_result (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .trans_valid_i (trans_valid),
    .trans_err_i   (trans_err),
    .wr_valid_i    (wr_valid),
    .wr_err_i      (wr_err),
    .fuse_words_i  (fuse_words),
    .lc_state_i    (lc_state),
    .zeroize_i     (zeroize_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_err_o     (rsp_err_o),
    .broadcast_o   (broadcast_o)
  );

  assign lc_state_o  = lc_state;
  assign escalated_o = escalated;

endmodule

// ==== verilog/fuse_result.sv ====
`include "lc_fuse_params.svh"

module fuse_result (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         trans_valid_i,
  input  lc_fuse_pkg::lc_err_e         trans_err_i,
  input  logic                         wr_valid_i,
  input  lc_fuse_pkg::lc_err_e         wr_err_i,
  input  logic [`LC_FUSE_BCAST_W-1:0]  fuse_words_i,
  input  lc_fuse_pkg::lc_state_e       lc_state_i,
  input  logic                         zeroize_i,
  output logic                         rsp_valid_o,
  output lc_fuse_pkg::lc_err_e         rsp_err_o,
  output logic [`LC_FUSE_BCAST_W-1:0]  broadcast_o
);

  logic                        any_valid;
  logic                        kill_bcast;
  lc_fuse_pkg::lc_err_e        err_d;

  logic                        rsp_valid_q;
  lc_fuse_pkg::lc_err_e        rsp_err_q;
  logic [`LC_FUSE_BCAST_W-1:0] bcast_q;

  // At most one execute block answers in a given cycle
  assign any_valid = trans_valid_i | wr_valid_i;

  // Pick the code of whichever block pulsed
  assign err_d = trans_valid_i ? trans_err_i : wr_err_i;

  // Zeroize command or a scrapped part hides every fuse word
  assign kill_bcast = zeroize_i || (lc_state_i == lc_fuse_pkg::SCRAP);

  // Response strobe and broadcast register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      bcast_q     <= '0;
    end else begin
      rsp_valid_q <= any_valid;
      if (kill_bcast) begin
        bcast_q <= '0;
      end else begin
        bcast_q <= fuse_words_i;
      end
    end
  end

  // Response code follows the strobe
  always_ff @(posedge clk_i) begin
    if (any_valid) begin
      rsp_err_q <= err_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  // Released words reappear one cycle after zeroize drops
  assign broadcast_o = bcast_q;

endmodule

// ==== verilog/fuse_write_filter.sv ====
`include "lc_fuse_params.svh"

module fuse_write_filter (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         dec_valid_i,
  input  lc_fuse_pkg::lc_op_e          dec_op_i,
  input  logic [`LC_FUSE_PART_W-1:0]   dec_part_i,
  input  logic [`LC_FUSE_WORD_W-1:0]   dec_data_i,
  input  lc_fuse_pkg::lc_state_e       lc_state_i,
  input  logic                         escalated_i,
  output logic                         wr_valid_o,
  output lc_fuse_pkg::lc_err_e         wr_err_o,
  output logic [`LC_FUSE_BCAST_W-1:0]  fuse_words_o
);

  logic                 wr_cmd;
  logic                 wr_en;
  lc_fuse_pkg::lc_err_e err_d;

  // One word per partition, partition 0 in the low bits
  logic [`LC_FUSE_NUM_PART-1:0][`LC_FUSE_WORD_W-1:0] fuse_q;
  logic                                              wr_valid_q;
  lc_fuse_pkg::lc_err_e                              wr_err_q;

  // Only fuse writes land here
  assign wr_cmd = dec_valid_i && (dec_op_i == lc_fuse_pkg::OpWrite);

  // Write-lock filter in priority order
  always_comb begin
    wr_en = 1'b0;
    err_d = lc_fuse_pkg::NoError;
    if (escalated_i) begin
      err_d = lc_fuse_pkg::EscError;
    end else if (dec_part_i == `LC_FUSE_PART_W'(lc_fuse_pkg::LC_PART_IDX)) begin
      // Life-cycle partition changes only through transitions
      err_d = lc_fuse_pkg::AccessError;
    end else if (lc_state_i > lc_fuse_pkg::PART_LC_PHASE[dec_part_i]) begin
      // Phase of this partition has expired
      err_d = lc_fuse_pkg::AccessError;
    end else begin
      wr_en = 1'b1;
    end
  end

  // Fuse array and response strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fuse_q     <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= wr_cmd;
      // OTP bits can only be set, never cleared
      if (wr_cmd && wr_en) begin
        fuse_q[dec_part_i] <= fuse_q[dec_part_i] | dec_data_i;
      end
    end
  end

  // Response code travels with the strobe
  always_ff @(posedge clk_i) begin
    if (wr_cmd) begin
      wr_err_q <= err_d;
    end
  end

  assign wr_valid_o   = wr_valid_q;
  assign wr_err_o     = wr_err_q;
  assign fuse_words_o = fuse_q;

endmodule

// ==== verilog/lc_state_transition.sv ====
module lc_state_transition (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   dec_valid_i,
  input  lc_fuse_pkg::lc_op_e    dec_op_i,
  input  lc_fuse_pkg::lc_state_e dec_target_i,
  input  logic                   ppd_i,
  input  logic                   escalate_i,
  output lc_fuse_pkg::lc_state_e lc_state_o,
  output logic                   escalated_o,
  output logic                   trans_valid_o,
  output lc_fuse_pkg::lc_err_e   trans_err_o
);

  logic                   trans_cmd;
  logic                   tgt_needs_ppd;
  lc_fuse_pkg::lc_state_e state_d;
  lc_fuse_pkg::lc_err_e   err_d;

  lc_fuse_pkg::lc_state_e state_q;
  logic                   escalated_q;
  logic                   trans_valid_q;
  lc_fuse_pkg::lc_err_e   trans_err_q;

  // Everything except fuse writes is answered here
  // Illegal opcodes included so that each command gets one answer
  assign trans_cmd = dec_valid_i && (dec_op_i != lc_fuse_pkg::OpWrite);

  // Terminal states that demand physical presence
  assign tgt_needs_ppd = (dec_target_i == lc_fuse_pkg::RMA) ||
                         (dec_target_i == lc_fuse_pkg::SCRAP);

  // Transition rules in priority order
  always_comb begin
    state_d = state_q;
    err_d   = lc_fuse_pkg::NoError;
    if (escalated_q) begin
      // Sticky refusal once escalation has been seen
      err_d = lc_fuse_pkg::EscError;
    end else if (dec_op_i == lc_fuse_pkg::OpIllegal) begin
      err_d = lc_fuse_pkg::OpcodeError;
    end else if (dec_target_i <= state_q) begin
      // Rollback or same-state request
      err_d = lc_fuse_pkg::TransError;
    end else if ((state_q == lc_fuse_pkg::PROD_END) &&
                 (dec_target_i == lc_fuse_pkg::RMA)) begin
      // End of production may only go to SCRAP
      err_d = lc_fuse_pkg::TransError;
    end else if (tgt_needs_ppd && !ppd_i) begin
      err_d = lc_fuse_pkg::TransError;
    end else begin
      state_d = dec_target_i;
    end
  end

  // State, escalation flag and response strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= lc_fuse_pkg::RAW;
      escalated_q   <= 1'b0;
      trans_valid_q <= 1'b0;
    end else begin
      // Only reset clears escalation
      escalated_q   <= escalated_q | escalate_i;
      trans_valid_q <= trans_cmd;
      if (trans_cmd) begin
        state_q <= state_d;
      end
    end
  end

  // Response code travels with the strobe
  always_ff @(posedge clk_i) begin
    if (trans_cmd) begin
      trans_err_q <= err_d;
    end
  end

  // New state is seen by the next command in its execute cycle
  assign lc_state_o    = state_q;
  assign escalated_o   = escalated_q;
  assign trans_valid_o = trans_valid_q;
  assign trans_err_o   = trans_err_q;

endmodule

// ==== verilog/lc_cmd_decode.sv ====
`include "lc_fuse_params.svh"

module lc_cmd_decode (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         cmd_valid_i,
  input  lc_fuse_pkg::lc_cmd_u         cmd_i,
  output logic                         dec_valid_o,
  output lc_fuse_pkg::lc_op_e          dec_op_o,
  output logic [`LC_FUSE_PART_W-1:0]   dec_part_o,
  output logic [`LC_FUSE_WORD_W-1:0]   dec_data_o,
  output lc_fuse_pkg::lc_state_e       dec_target_o
);

  lc_fuse_pkg::lc_op_e    op_d;
  lc_fuse_pkg::lc_state_e target_d;
  logic                   target_ok;

  logic                         valid_q;
  lc_fuse_pkg::lc_op_e          op_q;
  logic [`LC_FUSE_PART_W-1:0]   part_q;
  logic [`LC_FUSE_WORD_W-1:0]   data_q;
  lc_fuse_pkg::lc_state_e       target_q;

  // Raw target must name one of the eight states
  assign target_ok = (cmd_i.trans.target <= `LC_FUSE_TGT_W'(lc_fuse_pkg::SCRAP));

  // Low target bits are enough once the range is checked
  assign target_d = lc_fuse_pkg::lc_state_e'(cmd_i.trans.target[2:0]);

  // Opcode read through the write view
  // Same bits as the transition view
  always_comb begin
    op_d = lc_fuse_pkg::OpIllegal;
    if (cmd_i.wr.opcode == lc_fuse_pkg::OpWrite) begin
      op_d = lc_fuse_pkg::OpWrite;
    end else if (cmd_i.trans.opcode == lc_fuse_pkg::OpTrans) begin
      // Out of range target turns the whole command illegal
      if (target_ok) begin
        op_d = lc_fuse_pkg::OpTrans;
      end
    end
  end

  // Strobe register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= cmd_valid_i;
    end
  end

  // Decoded fields follow the strobe
  // Both views are captured, the execute stage picks by opcode
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      op_q     <= op_d;
      part_q   <= cmd_i.wr.partition;
      data_q   <= cmd_i.wr.data;
      target_q <= target_d;
    end
  end

  assign dec_valid_o  = valid_q;
  assign dec_op_o     = op_q;
  assign dec_part_o   = part_q;
  assign dec_data_o   = data_q;
  assign dec_target_o = target_q;

endmodule

// ==== verilog/lc_fuse_pkg.sv ====
`include "lc_fuse_params.svh"

package lc_fuse_pkg;

  // Ordered life-cycle states
  // Numeric order is the only legal direction of travel
  typedef enum logic [2:0] {
    RAW           = 3'd0,
    TEST_UNLOCKED = 3'd1,
    TEST_LOCKED   = 3'd2,
    DEV           = 3'd3,
    PROD          = 3'd4,
    PROD_END      = 3'd5,
    RMA           = 3'd6,
    SCRAP         = 3'd7
  } lc_state_e;

  // Decoded opcode
  // Raw codes 0 and 3 both end up as OpIllegal
  typedef enum logic [`LC_FUSE_OP_W-1:0] {
    OpIllegal = 2'd0,
    OpWrite   = 2'd1,
    OpTrans   = 2'd2
  } lc_op_e;

  // Response codes
  typedef enum logic [2:0] {
    NoError     = 3'd0,
    AccessError = 3'd1,
    TransError  = 3'd2,
    EscError    = 3'd3,
    OpcodeError = 3'd4
  } lc_err_e;

  // Fuse write view of the command word
  typedef struct packed {
    logic [`LC_FUSE_OP_W-1:0]   opcode;
    logic [`LC_FUSE_PART_W-1:0] partition;
    logic [`LC_FUSE_CMD_W-`LC_FUSE_OP_W-`LC_FUSE_PART_W-`LC_FUSE_WORD_W-1:0] unused;
    logic [`LC_FUSE_WORD_W-1:0] data;
  } fuse_write_cmd_t;

  // Transition request view of the command word
  typedef struct packed {
    logic [`LC_FUSE_OP_W-1:0]  opcode;
    logic [`LC_FUSE_TGT_W-1:0] target;
    logic [`LC_FUSE_CMD_W-`LC_FUSE_OP_W-`LC_FUSE_TGT_W-1:0] unused;
  } lc_trans_cmd_t;

  // Opcode sits in the same bits of both views
  typedef union packed {
    fuse_write_cmd_t wr;
    lc_trans_cmd_t   trans;
  } lc_cmd_u;

  // Index of the life-cycle partition
  localparam int unsigned LC_PART_IDX = `LC_FUSE_NUM_PART - 1;

  // Last state in which each partition still takes writes
  // Entry for the life-cycle partition is never consulted
  localparam lc_state_e PART_LC_PHASE [`LC_FUSE_NUM_PART] = '{
    TEST_LOCKED,
    DEV,
    PROD,
    RAW
  };

endpackage

// ==== verilog/lc_fuse_params.svh ====
`ifndef LC_FUSE_PARAMS_SVH
`define LC_FUSE_PARAMS_SVH

// Width of one command word
`define LC_FUSE_CMD_W 32

// Opcode field in the top bits of every command
`define LC_FUSE_OP_W 2

// Fuse partitions, the last one holds the life-cycle state
`define LC_FUSE_NUM_PART 4
`define LC_FUSE_PART_W 2

// One fuse word per partition
`define LC_FUSE_WORD_W 16

// Raw target field of a transition command
`define LC_FUSE_TGT_W 4

// All fuse words side by side
`define LC_FUSE_BCAST_W (`LC_FUSE_NUM_PART * `LC_FUSE_WORD_W)

`endif
